// ==== Makefile ====
# Verilator build and run of the enable-pulse generator testbench

TOP = tb_enable_gen

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f vlog.f

run: compile
	-./obj_dir/V$(TOP) > sim.log 2>&1
	cat sim.log
	@if grep -q "TB FAILED" sim.log; then \
		echo "Simulation reported a failure"; exit 1; \
	fi
	@if ! grep -q "TB PASSED" sim.log; then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// ==== enable_gen_channels.sv ====
// Threshold comparators, one registered enable pulse per match.
// Outputs lag the matching count by one cycle.
`timescale 1ns/1ns
`default_nettype none

module enable_gen_channels (
    input  wire logic                                  clock,
    input  wire logic                                  reset,
    gen_config_if.sink                                 gen_config,
    input  wire logic [enable_gen_pkg::DATA_WIDTH-1:0] count,
    input  wire logic                                  active,
    output      logic [enable_gen_pkg::N_CHANNELS-1:0] enable_out
);

    logic [enable_gen_pkg::N_CHANNELS-1:0] match;

    // One comparator per channel
    for (genvar n = 0; n < enable_gen_pkg::N_CHANNELS; n++) begin : g_channel
        assign match[n] = active && (count == gen_config.threshold[n]);
    end

    // With period zero the count sits at zero, so a zero threshold stays high
    always_ff @(posedge clock) begin
        if (!reset) begin
            enable_out <= '0;
        end else begin
            enable_out <= match;
        end
    end

endmodule

`default_nettype wire

// ==== enable_gen_counter.sv ====
// Free-running period counter, wraps to zero after reaching the period.
// A period below the current count only takes effect after the 32-bit wrap.
`timescale 1ns/1ns
`default_nettype none

module enable_gen_counter (
    input  wire logic                                  clock,
    input  wire logic                                  reset,
    input  wire logic                                  start,
    gen_config_if.sink                                 gen_config,
    output      logic [enable_gen_pkg::DATA_WIDTH-1:0] count,
    output      logic                                  active
);

    // Either the run bit or the external start keeps the counter going
    assign active = gen_config.run | start;

    always_ff @(posedge clock) begin
        if (!reset) begin
            count <= '0;
        end else if (!active) begin
            // Idle counter restarts from zero on reactivation
            count <= '0;
        end else if (count == gen_config.period) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== enable_gen_ifs.sv ====
// Internal interfaces of the enable-pulse generator.
// host_bus_if follows the four-phase req/ack rule; gen_config_if is static config.
`timescale 1ns/1ns
`default_nettype none

interface host_bus_if;
    logic                                 req;
    logic                                 write;
    logic [enable_gen_pkg::ADDR_WIDTH-1:0] address;
    logic [enable_gen_pkg::DATA_WIDTH-1:0] write_data;
    logic                                 ack;
    logic [enable_gen_pkg::DATA_WIDTH-1:0] read_data;

    modport top   (output req, write, address, write_data, input ack, read_data);
    modport slave (input req, write, address, write_data, output ack, read_data);
endinterface

interface gen_config_if;
    logic                                 run;
    logic [enable_gen_pkg::DATA_WIDTH-1:0] period;
    // One compare value per channel
    logic [enable_gen_pkg::DATA_WIDTH-1:0] threshold [enable_gen_pkg::N_CHANNELS];

    modport source (output run, period, threshold);
    modport sink   (input run, period, threshold);
endinterface

`default_nettype wire

// ==== enable_gen_pkg.sv ====
// Shared sizes and register map of the enable-pulse generator.
// Offsets are byte addresses local to the block; no base address is decoded.
`default_nettype none

package enable_gen_pkg;

    // Bus word, counter, period and threshold width
    localparam int DATA_WIDTH = 32;

    // Byte address width of the host bus
    localparam int ADDR_WIDTH = 8;

    // Number of comparator channels
    localparam int N_CHANNELS = 3;

    // Register map
    localparam logic [ADDR_WIDTH-1:0] ADDR_CONTROL        = 8'h00;
    localparam logic [ADDR_WIDTH-1:0] ADDR_PERIOD         = 8'h04;
    localparam logic [ADDR_WIDTH-1:0] ADDR_THRESHOLD_BASE = 8'h08;
    localparam logic [ADDR_WIDTH-1:0] ADDR_STRIDE         = 8'h04;

    // Run bit position in the control register, other bits read as zero
    localparam int RUN_BIT = 0;

    // Bus slave FSM encoding
    localparam int STATE_WIDTH = 2;

    // Waiting for a synchronised req
    localparam logic [STATE_WIDTH-1:0] STATE_IDLE        = 2'd0;
    // Access done, ack held until req drops
    localparam logic [STATE_WIDTH-1:0] STATE_ACKNOWLEDGE = 2'd1;
    // req seen low, ack drops on the next edge
    localparam logic [STATE_WIDTH-1:0] STATE_RELEASE     = 2'd2;

endpackage

`default_nettype wire

// ==== enable_gen_regs.sv ====
// Register block behind the four-phase req/ack bus, one access in flight.
// Unmapped writes are dropped and unmapped reads return zero.
`timescale 1ns/1ns
`default_nettype none

module enable_gen_regs (
    input wire logic       clock,
    input wire logic       reset,
    host_bus_if.slave      bus,
    gen_config_if.source   gen_config
);

    logic                                   req_q;
    logic [enable_gen_pkg::STATE_WIDTH-1:0] state;

    logic                                   run_reg;
    logic [enable_gen_pkg::DATA_WIDTH-1:0]  period_reg;
    logic [enable_gen_pkg::DATA_WIDTH-1:0]  threshold_reg [enable_gen_pkg::N_CHANNELS];

    logic                                   sel_control;
    logic                                   sel_period;
    logic [enable_gen_pkg::N_CHANNELS-1:0]  sel_threshold;
    logic [enable_gen_pkg::DATA_WIDTH-1:0]  read_value;

    // Address decode and read mux, address is stable while req is high
    always_comb begin
        logic [enable_gen_pkg::ADDR_WIDTH-1:0] offset;

        sel_control   = (bus.address == enable_gen_pkg::ADDR_CONTROL);
        sel_period    = (bus.address == enable_gen_pkg::ADDR_PERIOD);
        sel_threshold = '0;
        read_value    = '0;

        if (sel_control) begin
            read_value[enable_gen_pkg::RUN_BIT] = run_reg;
        end
        if (sel_period) begin
            read_value = period_reg;
        end

        // Thresholds sit at consecutive strided offsets
        offset = enable_gen_pkg::ADDR_THRESHOLD_BASE;
        for (int n = 0; n < enable_gen_pkg::N_CHANNELS; n++) begin
            if (bus.address == offset) begin
                sel_threshold[n] = 1'b1;
                read_value       = threshold_reg[n];
            end
            offset = offset + enable_gen_pkg::ADDR_STRIDE;
        end
    end

    // Handshake FSM with register update
    always_ff @(posedge clock) begin
        if (!reset) begin
            req_q         <= 1'b0;
            state         <= enable_gen_pkg::STATE_IDLE;
            bus.ack       <= 1'b0;
            bus.read_data <= '0;
            run_reg       <= 1'b0;
            period_reg    <= '0;
            for (int n = 0; n < enable_gen_pkg::N_CHANNELS; n++) begin
                threshold_reg[n] <= '0;
            end
        end else begin
            // req comes from the host clock domain view, sample it first
            req_q <= bus.req;

            case (state)
                enable_gen_pkg::STATE_IDLE: begin
                    if (req_q) begin
                        state   <= enable_gen_pkg::STATE_ACKNOWLEDGE;
                        bus.ack <= 1'b1;
                        if (bus.write) begin
                            if (sel_control) begin
                                run_reg <= bus.write_data[enable_gen_pkg::RUN_BIT];
                            end
                            if (sel_period) begin
                                period_reg <= bus.write_data;
                            end
                            for (int n = 0; n < enable_gen_pkg::N_CHANNELS; n++) begin
                                if (sel_threshold[n]) begin
                                    threshold_reg[n] <= bus.write_data;
                                end
                            end
                        end else begin
                            bus.read_data <= read_value;
                        end
                    end
                end

                enable_gen_pkg::STATE_ACKNOWLEDGE: begin
                    // Host may hold req as long as it likes
                    if (!req_q) begin
                        state <= enable_gen_pkg::STATE_RELEASE;
                    end
                end

                enable_gen_pkg::STATE_RELEASE: begin
                    bus.ack <= 1'b0;
                    state   <= enable_gen_pkg::STATE_IDLE;
                end

                default: begin
                    bus.ack <= 1'b0;
                    state   <= enable_gen_pkg::STATE_IDLE;
                end
            endcase
        end
    end

    // Registers out to the counter and channels
    assign gen_config.run       = run_reg;
    assign gen_config.period    = period_reg;
    assign gen_config.threshold = threshold_reg;

endmodule

`default_nettype wire

// ==== enable_gen_top.sv ====
// Enable-pulse generator top with plain host bus ports.
// Host must follow the four-phase req/ack rule; start ORs with the run bit.
`timescale 1ns/1ns
`default_nettype none

module enable_gen_top (
    input  wire logic                                  clock,
    input  wire logic                                  reset,
    input  wire logic                                  req,
    input  wire logic                                  write,
    input  wire logic [enable_gen_pkg::ADDR_WIDTH-1:0] address,
    input  wire logic [enable_gen_pkg::DATA_WIDTH-1:0] write_data,
    output      logic                                  ack,
    output      logic [enable_gen_pkg::DATA_WIDTH-1:0] read_data,
    input  wire logic                                  start,
    output      logic [enable_gen_pkg::N_CHANNELS-1:0] enable_out
);

    logic [enable_gen_pkg::DATA_WIDTH-1:0] count;
    logic                                  active;

    host_bus_if   host_bus ();
    gen_config_if gen_config ();

    // Host side of the bus from the plain ports
    assign host_bus.req        = req;
    assign host_bus.write      = write;
    assign host_bus.address    = address;
    assign host_bus.write_data = write_data;
    assign ack                 = host_bus.ack;
    assign read_data           = host_bus.read_data;

    enable_gen_regs i_regs (
        .clock      (clock),
        .reset      (reset),
        .bus        (host_bus.slave),
        .gen_config (gen_config.source)
    );

    enable_gen_counter i_counter (
        .clock      (clock),
        .reset      (reset),
        .start      (start),
        .gen_config (gen_config.sink),
        .count      (count),
        .active     (active)
    );

    enable_gen_channels i_channels (
        .clock      (clock),
        .reset      (reset),
        .gen_config (gen_config.sink),
        .count      (count),
        .active     (active),
        .enable_out (enable_out)
    );

endmodule

`default_nettype wire

// ==== tb_enable_gen.sv ====
// Testbench top: random host accesses and start toggling from a fixed seed.
// The reference model and all comparisons live in the checker instance.
`timescale 1ns/1ns
`default_nettype none

module tb_enable_gen;

    localparam int AW                = enable_gen_pkg::ADDR_WIDTH;
    localparam int DW                = enable_gen_pkg::DATA_WIDTH;
    localparam int NC                = enable_gen_pkg::N_CHANNELS;
    localparam int CLOCK_PERIOD      = 10;
    localparam int RESET_CYCLES      = 8;
    localparam int N_ACCESSES        = 200;
    localparam int CYCLES_PER_ACCESS = 80;
    localparam int WATCHDOG_CYCLES   = N_ACCESSES * CYCLES_PER_ACCESS + 500;

    logic          clock;
    logic          reset;
    logic          req;
    logic          write;
    logic [AW-1:0] address;
    logic [DW-1:0] write_data;
    logic          ack;
    logic [DW-1:0] read_data;
    logic          start;
    logic [NC-1:0] enable_out;
    int            error_count;
    int            check_count;
    integer        seed = 32'h02f2_79cc;

    enable_gen_top i_dut (
        .clock      (clock),
        .reset      (reset),
        .req        (req),
        .write      (write),
        .address    (address),
        .write_data (write_data),
        .ack        (ack),
        .read_data  (read_data),
        .start      (start),
        .enable_out (enable_out)
    );

    tb_enable_gen_checker i_checker (
        .clock       (clock),
        .reset       (reset),
        .req         (req),
        .write       (write),
        .address     (address),
        .write_data  (write_data),
        .ack         (ack),
        .read_data   (read_data),
        .start       (start),
        .enable_out  (enable_out),
        .error_count (error_count),
        .check_count (check_count)
    );

    initial clock = 1'b0;
    always #(CLOCK_PERIOD / 2) clock = ~clock;

    function automatic int unsigned rand_below(input int unsigned limit);
        return $unsigned($random(seed)) % limit;
    endfunction

    // Index 0 control, 1 period, 2 and up thresholds
    function automatic logic [AW-1:0] register_address(input int unsigned index);
        if (index == 0) begin
            return enable_gen_pkg::ADDR_CONTROL;
        end
        if (index == 1) begin
            return enable_gen_pkg::ADDR_PERIOD;
        end
        return enable_gen_pkg::ADDR_THRESHOLD_BASE + AW'((index - 2) * 4);
    endfunction

    function automatic logic [AW-1:0] unmapped_address();
        if (rand_below(2) == 1) begin
            return AW'(8'h14 + rand_below(8'hec));
        end
        // Misaligned inside the register map
        return register_address(rand_below(5)) + AW'(1 + rand_below(3));
    endfunction

    task automatic idle_cycles(input int unsigned cycles);
        repeat (cycles) begin
            @(posedge clock);
            if (rand_below(12) == 0) begin
                start <= ~start;
            end
        end
    endtask

    // One four-phase access, req held 0 to 3 extra cycles after ack
    task automatic bus_access(input logic is_write, input logic [AW-1:0] addr,
                              input logic [DW-1:0] data);
        int unsigned hold;
        hold = rand_below(4);
        @(posedge clock);
        req        <= 1'b1;
        write      <= is_write;
        address    <= addr;
        write_data <= data;
        @(posedge clock);
        while (!ack) @(posedge clock);
        repeat (hold) @(posedge clock);
        req <= 1'b0;
        @(posedge clock);
        while (ack) @(posedge clock);
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLOCK_PERIOD);
        $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        int unsigned kind;

        reset      = 1'b0;
        req        = 1'b0;
        write      = 1'b0;
        address    = '0;
        write_data = '0;
        start      = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b1;
        idle_cycles(4);

        for (int i = 0; i < N_ACCESSES; i++) begin
            kind = rand_below(16);
            if (kind < 3) begin
                bus_access(1'b0, register_address(rand_below(5)), '0);
            end else if (kind == 3) begin
                bus_access(rand_below(2) == 1, unmapped_address(), $random(seed));
            end else if (kind < 7) begin
                bus_access(1'b1, enable_gen_pkg::ADDR_CONTROL, $random(seed));
            end else if (kind < 9) begin
                // Stop the counter so a shorter period never sits below the count
                @(posedge clock);
                start <= 1'b0;
                bus_access(1'b1, enable_gen_pkg::ADDR_CONTROL, '0);
                bus_access(1'b1, enable_gen_pkg::ADDR_PERIOD, DW'(rand_below(41)));
            end else begin
                bus_access(1'b1, register_address(2 + rand_below(3)), DW'(rand_below(46)));
            end
            idle_cycles(rand_below(61));
        end

        repeat (10) @(posedge clock);
        $display("Checks: %0d cycles compared, %0d errors", check_count, error_count);
        if (error_count == 0 && check_count > 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb_enable_gen_assertions.sv ====
// Concurrent checks on the host handshake and idle outputs, bound into the top.
// Needs concurrent assertion support switched on in the simulator.
`timescale 1ns/1ns
`default_nettype none

module tb_enable_gen_assertions (
    input wire logic                                  clock,
    input wire logic                                  reset,
    input wire logic                                  req,
    input wire logic                                  ack,
    input wire logic [enable_gen_pkg::DATA_WIDTH-1:0] read_data,
    input wire logic                                  run,
    input wire logic                                  start,
    input wire logic [enable_gen_pkg::DATA_WIDTH-1:0] count,
    input wire logic [enable_gen_pkg::N_CHANNELS-1:0] enable_out
);

    // Neither the run bit nor start keeps the generator going
    logic inactive;

    assign inactive = !run && !start;

    // ack only rises on a request the host is still holding
    ack_rises_with_req: assert property (
        @(posedge clock) disable iff (!reset) $rose(ack) |-> (req && $past(req)))
        else $error("ack rose without a pending req");

    ack_held_until_release: assert property (
        @(posedge clock) disable iff (!reset) (ack && req) |=> ack)
        else $error("ack dropped while req was still high");

    // Read data is loaded once per access
    read_data_stable: assert property (
        @(posedge clock) disable iff (!reset) (ack && $past(ack)) |-> $stable(read_data))
        else $error("read_data changed while ack was high");

    outputs_low_when_idle: assert property (
        @(posedge clock) disable iff (!reset) inactive |=> (enable_out == '0))
        else $error("enable_out high after an inactive cycle");

    count_cleared_when_idle: assert property (
        @(posedge clock) disable iff (!reset) inactive |=> (count == '0))
        else $error("count not cleared after an inactive cycle");

endmodule

bind enable_gen_top tb_enable_gen_assertions i_assertions (
    .clock      (clock),
    .reset      (reset),
    .req        (req),
    .ack        (ack),
    .read_data  (read_data),
    .run        (gen_config.run),
    .start      (start),
    .count      (count),
    .enable_out (enable_out)
);

`default_nettype wire

// ==== tb_enable_gen_checker.sv ====
// Reference model of the enable-pulse generator, watching only the top-level ports.
// Model updates on the rising edge and compares on the falling edge.
`timescale 1ns/1ns
`default_nettype none

module tb_enable_gen_checker (
    input  wire logic                                  clock,
    input  wire logic                                  reset,
    input  wire logic                                  req,
    input  wire logic                                  write,
    input  wire logic [enable_gen_pkg::ADDR_WIDTH-1:0] address,
    input  wire logic [enable_gen_pkg::DATA_WIDTH-1:0] write_data,
    input  wire logic                                  ack,
    input  wire logic [enable_gen_pkg::DATA_WIDTH-1:0] read_data,
    input  wire logic                                  start,
    input  wire logic [enable_gen_pkg::N_CHANNELS-1:0] enable_out,
    output      int                                    error_count,
    output      int                                    check_count
);

    localparam int AW = enable_gen_pkg::ADDR_WIDTH;
    localparam int DW = enable_gen_pkg::DATA_WIDTH;
    localparam int NC = enable_gen_pkg::N_CHANNELS;

    // Handshake phases of the modelled slave
    localparam int PHASE_WAIT = 0;
    localparam int PHASE_HOLD = 1;
    localparam int PHASE_DROP = 2;

    int          errors = 0;
    int          checks = 0;
    logic        model_valid = 1'b0;
    int          phase;
    logic        req_seen;
    logic        exp_ack;
    logic [DW-1:0] exp_read_data;
    logic        exp_run;
    logic [DW-1:0] exp_period;
    logic [DW-1:0] exp_threshold [NC];
    logic [DW-1:0] exp_count;
    logic [NC-1:0] exp_enable;

    assign error_count = errors;
    assign check_count = checks;

    // Channel number for a threshold offset, -1 when not a threshold
    function automatic int threshold_index(input logic [AW-1:0] addr);
        int offset;
        offset = int'(addr) - int'(enable_gen_pkg::ADDR_THRESHOLD_BASE);
        if (offset < 0 || offset % int'(enable_gen_pkg::ADDR_STRIDE) != 0) begin
            return -1;
        end
        offset = offset / int'(enable_gen_pkg::ADDR_STRIDE);
        if (offset >= NC) begin
            return -1;
        end
        return offset;
    endfunction

    function automatic logic [DW-1:0] register_value(input logic [AW-1:0] addr);
        int chan;
        chan = threshold_index(addr);
        if (addr == enable_gen_pkg::ADDR_CONTROL) begin
            return {{(DW-1){1'b0}}, exp_run};
        end
        if (addr == enable_gen_pkg::ADDR_PERIOD) begin
            return exp_period;
        end
        if (chan >= 0) begin
            return exp_threshold[chan];
        end
        // Unmapped offsets read zero
        return '0;
    endfunction

    task automatic mirror_write(input logic [AW-1:0] addr, input logic [DW-1:0] data);
        int chan;
        chan = threshold_index(addr);
        if (addr == enable_gen_pkg::ADDR_CONTROL) begin
            exp_run = data[0];
        end else if (addr == enable_gen_pkg::ADDR_PERIOD) begin
            exp_period = data;
        end else if (chan >= 0) begin
            exp_threshold[chan] = data;
        end
    endtask

    always @(posedge clock) begin
        logic active_now;

        if (!reset) begin
            phase         = PHASE_WAIT;
            req_seen      = 1'b0;
            exp_ack       = 1'b0;
            exp_read_data = '0;
            exp_run       = 1'b0;
            exp_period    = '0;
            exp_count     = '0;
            exp_enable    = '0;
            for (int n = 0; n < NC; n++) begin
                exp_threshold[n] = '0;
            end
            model_valid = 1'b1;
        end else begin
            // Counter and pulses see the configuration from before this edge
            active_now = exp_run | start;
            for (int n = 0; n < NC; n++) begin
                exp_enable[n] = active_now && (exp_count == exp_threshold[n]);
            end
            if (!active_now || exp_count == exp_period) begin
                exp_count = '0;
            end else begin
                exp_count = exp_count + 32'd1;
            end

            case (phase)
                PHASE_WAIT: begin
                    if (req_seen) begin
                        exp_ack = 1'b1;
                        phase   = PHASE_HOLD;
                        if (write) begin
                            mirror_write(address, write_data);
                        end else begin
                            exp_read_data = register_value(address);
                        end
                    end
                end
                PHASE_HOLD: begin
                    if (!req_seen) begin
                        phase = PHASE_DROP;
                    end
                end
                default: begin
                    exp_ack = 1'b0;
                    phase   = PHASE_WAIT;
                end
            endcase
            req_seen = req;
        end
    end

    always @(negedge clock) begin
        if (model_valid) begin
            checks++;
            if (ack !== exp_ack) begin
                errors++;
                $display("MISMATCH at %0t: ack is %b, expected %b", $time, ack, exp_ack);
            end
            if (read_data !== exp_read_data) begin
                errors++;
                $display("MISMATCH at %0t: read_data is %h, expected %h",
                         $time, read_data, exp_read_data);
            end
            if (enable_out !== exp_enable) begin
                errors++;
                $display("MISMATCH at %0t: enable_out is %b, expected %b (count %0d)",
                         $time, enable_out, exp_enable, exp_count);
            end
        end
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
enable_gen_pkg.sv
enable_gen_ifs.sv
enable_gen_regs.sv
enable_gen_counter.sv
enable_gen_channels.sv
enable_gen_top.sv
tb_enable_gen_assertions.sv
tb_enable_gen_checker.sv
tb_enable_gen.sv
